// File: sim.f
hw/fetch_pkg.sv
hw/host_mem_pkg.sv
hw/fetch_pc.sv
hw/instr_line_buffer.sv
hw/instr_select.sv
hw/fetch_top.sv
tests/fetch_clock.sv
tests/fetch_assertions.sv
tests/fetch_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the fetch stage testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
	--top-module fetch_tb \
	--Mdir obj_dir -o fetch_sim \
	-f sim.f

# the simulation result is taken from the log, not the exit code
./obj_dir/fetch_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^Test OK$" sim.log; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi

// File: tests/fetch_tb.sv
// fetch stage testbench
// stimulus table with expected pc and instruction, host memory model
// typed compare tasks, watchdog and final verdict

`timescale 1ns/100ps

module fetch_tb
	import fetch_pkg::*;
	import host_mem_pkg::*;
();

	localparam int PERIOD       = 20;
	localparam int RESET_CYCLES = 8;
	localparam int NUM_ROWS     = 17;
	localparam int DONE_LIMIT   = 20;
	// worst refill fits in 12 cycles per row
	localparam int WATCHDOG_CYCLES = NUM_ROWS*12 + RESET_CYCLES;

	localparam logic [31:0] LFSR_SEED = 32'hc44b;
	localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
	localparam instr_t CPU_INJ = 32'h1357_9bdf;
	localparam instr_t INT_INJ = 32'h2468_ace0;

	// one stimulus step and what it must produce
	typedef struct packed {
		addr_t  in_pc_next;
		logic   stall;
		logic   flush;
		logic   restore;
		addr_t  pc_before_int;
		logic   use_cpu;
		instr_t cpu_inj;
		logic   use_int;
		instr_t int_inj;
		logic   check;
		addr_t  exp_pc;
		instr_t exp_instr;
	} row_t;

	logic clk;
	logic rst_n;
	addr_t in_pc_next;
	logic stall;
	logic flush;
	logic restore;
	addr_t pc_before_int;
	logic use_cpu_injection;
	instr_t cpu_injection;
	logic use_int_instr;
	instr_t int_instr;
	line_t data_in_host;
	logic rd_valid_host;
	instr_t instr;
	addr_t current_pc;
	logic done;
	addr_t addr_out_host;
	host_op_t op_host;

	row_t rows [NUM_ROWS];
	logic [31:0] lfsr_state = LFSR_SEED;
	int value_errors = 0;
	int other_errors = 0;

	fetch_clock #(.PERIOD(PERIOD), .RESET_CYCLES(RESET_CYCLES)) u_clk (
		.clk  (clk),
		.rst_n(rst_n)
	);

	fetch_top u_dut (
		.clk              (clk),
		.rst_n            (rst_n),
		.in_pc_next       (in_pc_next),
		.stall            (stall),
		.flush            (flush),
		.restore          (restore),
		.pc_before_int    (pc_before_int),
		.use_cpu_injection(use_cpu_injection),
		.cpu_injection    (cpu_injection),
		.use_int_instr    (use_int_instr),
		.int_instr        (int_instr),
		.data_in_host     (data_in_host),
		.rd_valid_host    (rd_valid_host),
		.instr            (instr),
		.current_pc       (current_pc),
		.done             (done),
		.addr_out_host    (addr_out_host),
		.op_host          (op_host)
	);

	// memory content rule, word at byte address a
	function automatic instr_t mem_word(addr_t a);
		return a ^ 32'hA5A5_0000;
	endfunction

	// full line starting at a line base, word 0 in the low bits
	function automatic line_t line_for(addr_t base);
		line_t l;
		l = '0;
		for (int i = 0; i < LINE_WORDS; i++) begin
			l[i*32 +: 32] = mem_word(base + addr_t'(i*4));
		end
		return l;
	endfunction

	// galois lfsr, one step per bit drawn
	function automatic logic lfsr_step();
		logic out;
		out = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (out) begin
			lfsr_state = lfsr_state ^ LFSR_TAPS;
		end
		return out;
	endfunction

	// host answer latency 1 to 8 cycles
	function automatic int draw_latency();
		logic [2:0] bits;
		for (int i = 0; i < 3; i++) begin
			bits[i] = lfsr_step();
		end
		return 1 + int'(bits);
	endfunction

	// plain memory step, everything else quiet
	function automatic row_t plain_row(addr_t next, addr_t exp_pc, instr_t exp_instr);
		row_t r;
		r = '0;
		r.in_pc_next = next;
		r.check = 1'b1;
		r.exp_pc = exp_pc;
		r.exp_instr = exp_instr;
		return r;
	endfunction

	task automatic check_addr(input int row, input string name, input addr_t got,
			input addr_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("FAILED %s row %0d: got %h expected %h", name, row, got, exp);
		end
	endtask

	task automatic check_instr(input int row, input string name, input instr_t got,
			input instr_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("FAILED %s row %0d: got %h expected %h", name, row, got, exp);
		end
	endtask

	task automatic load_table();
		// reset pc held, first refill
		rows[0] = plain_row(RESET_PC, RESET_PC, mem_word(RESET_PC));
		rows[0].stall = 1'b1;
		// sequential words, then across the line boundary
		rows[1] = plain_row(RESET_PC + 32'h04, RESET_PC + 32'h04, mem_word(RESET_PC + 32'h04));
		rows[2] = plain_row(RESET_PC + 32'h08, RESET_PC + 32'h08, mem_word(RESET_PC + 32'h08));
		rows[3] = plain_row(RESET_PC + 32'h3c, RESET_PC + 32'h3c, mem_word(RESET_PC + 32'h3c));
		rows[4] = plain_row(RESET_PC + 32'h40, RESET_PC + 32'h40, mem_word(RESET_PC + 32'h40));
		rows[5] = plain_row(RESET_PC + 32'h44, RESET_PC + 32'h44, mem_word(RESET_PC + 32'h44));
		// stall alone holds pc
		rows[6] = plain_row(RESET_PC + 32'h80, RESET_PC + 32'h44, mem_word(RESET_PC + 32'h44));
		rows[6].stall = 1'b1;
		// flush beats stall, NOP issued
		rows[7] = plain_row(RESET_PC + 32'h48, RESET_PC + 32'h48, NOP_INSTR);
		rows[7].stall = 1'b1;
		rows[7].flush = 1'b1;
		// restore beats both, flush still forces NOP
		rows[8] = plain_row(RESET_PC + 32'h200, RESET_PC + 32'h10, NOP_INSTR);
		rows[8].stall = 1'b1;
		rows[8].flush = 1'b1;
		rows[8].restore = 1'b1;
		rows[8].pc_before_int = RESET_PC + 32'h10;
		rows[9] = plain_row(RESET_PC + 32'h300, RESET_PC + 32'h14, mem_word(RESET_PC + 32'h14));
		rows[9].restore = 1'b1;
		rows[9].pc_before_int = RESET_PC + 32'h14;
		// injection priority
		rows[10] = plain_row(RESET_PC + 32'h18, RESET_PC + 32'h18, CPU_INJ);
		rows[10].use_cpu = 1'b1;
		rows[10].cpu_inj = CPU_INJ;
		rows[10].use_int = 1'b1;
		rows[10].int_inj = INT_INJ;
		rows[11] = plain_row(RESET_PC + 32'h1c, RESET_PC + 32'h1c, INT_INJ);
		rows[11].use_int = 1'b1;
		rows[11].int_inj = INT_INJ;
		rows[12] = rows[10];
		rows[12].in_pc_next = RESET_PC + 32'h20;
		rows[12].flush = 1'b1;
		rows[12].exp_pc = RESET_PC + 32'h20;
		rows[12].exp_instr = NOP_INSTR;
		// miss left unchecked, next row moves pc during the refill
		rows[13] = plain_row(RESET_PC + 32'h400, RESET_PC + 32'h400, mem_word(RESET_PC + 32'h400));
		rows[13].check = 1'b0;
		rows[14] = plain_row(RESET_PC + 32'h824, RESET_PC + 32'h824, mem_word(RESET_PC + 32'h824));
		rows[15] = plain_row(RESET_PC + 32'h828, RESET_PC + 32'h828, mem_word(RESET_PC + 32'h828));
		rows[16] = plain_row(RESET_PC + 32'h840, RESET_PC + 32'h840, mem_word(RESET_PC + 32'h840));
	endtask

	task automatic drive_row(input row_t r);
		in_pc_next <= r.in_pc_next;
		stall <= r.stall;
		flush <= r.flush;
		restore <= r.restore;
		pc_before_int <= r.pc_before_int;
		use_cpu_injection <= r.use_cpu;
		cpu_injection <= r.cpu_inj;
		use_int_instr <= r.use_int;
		int_instr <= r.int_inj;
	endtask

	// host memory controller model, one read at a time
	initial begin
		addr_t req_addr;
		int delay;
		rd_valid_host = 1'b0;
		data_in_host = '0;
		forever begin
			@(negedge clk);
			if (rst_n === 1'b1 && op_host == HOST_READ) begin
				req_addr = addr_out_host;
				delay = draw_latency();
				repeat (delay) @(posedge clk);
				data_in_host <= line_for(req_addr);
				rd_valid_host <= 1'b1;
				@(posedge clk);
				rd_valid_host <= 1'b0;
			end
		end
	end

	// watchdog
	initial begin
		#(WATCHDOG_CYCLES*PERIOD);
		$display("watchdog expired after %0d cycles, the table did not complete",
			WATCHDOG_CYCLES);
		$display("Test FAILED");
		$finish;
	end

	// stimulus and compare
	initial begin
		int wait_cycles;
		load_table();
		// hold pc at its reset value until the table starts
		in_pc_next = RESET_PC;
		stall = 1'b1;
		flush = 1'b0;
		restore = 1'b0;
		pc_before_int = '0;
		use_cpu_injection = 1'b0;
		cpu_injection = '0;
		use_int_instr = 1'b0;
		int_instr = '0;
		wait (rst_n === 1'b1);
		@(negedge clk);
		check_addr(-1, "current_pc", current_pc, RESET_PC);
		if (done !== 1'b0) begin
			other_errors++;
			$display("done is high right after reset although the buffer is empty");
		end
		for (int r = 0; r < NUM_ROWS; r++) begin
			@(posedge clk);
			drive_row(rows[r]);
			// pc takes the row's value on this edge
			@(posedge clk);
			if (rows[r].check) begin
				wait_cycles = 0;
				@(negedge clk);
				// play hazard unit, stall until the line is there
				while (done !== 1'b1 && wait_cycles < DONE_LIMIT) begin
					@(posedge clk);
					stall <= 1'b1;
					@(negedge clk);
					wait_cycles++;
				end
				if (done !== 1'b1) begin
					other_errors++;
					$display("row %0d: done did not rise within %0d cycles", r, DONE_LIMIT);
				end else begin
					check_addr(r, "current_pc", current_pc, rows[r].exp_pc);
					check_instr(r, "instr", instr, rows[r].exp_instr);
				end
			end
		end
		@(negedge clk);
		$display("checks finished: %0d value errors, %0d other errors",
			value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

// File: tests/fetch_assertions.sv
// concurrent checks on the fetch stage top-level ports
// host op encoding, line alignment of reads, done against own-line refill
// bound into every fetch_top instance

`timescale 1ns/100ps

module fetch_assertions
	import fetch_pkg::*;
	import host_mem_pkg::*;
(
	input logic     clk,
	input logic     rst_n,
	input logic     done,
	input addr_t    current_pc,
	input addr_t    addr_out_host,
	input host_op_t op_host
);

	// no read may go out while reset is held
	op_idle_in_reset: assert property (@(posedge clk) !rst_n |-> op_host == HOST_IDLE)
		else $error("host op not idle during reset");

	// reads always address a whole line
	read_line_aligned: assert property (@(posedge clk) disable iff (!rst_n)
		op_host == HOST_READ |-> addr_out_host[LINE_OFFSET_BITS-1:0] == '0)
		else $error("host read address %h not line aligned", addr_out_host);

	// fetch is read only
	never_write: assert property (@(posedge clk) disable iff (!rst_n)
		op_host != HOST_WRITE)
		else $error("host write issued by the fetch stage");

	// the line being refilled for pc cannot already be a hit
	no_done_on_own_refill: assert property (@(posedge clk) disable iff (!rst_n)
		!(done && op_host == HOST_READ &&
		addr_out_host[31:LINE_OFFSET_BITS] == current_pc[31:LINE_OFFSET_BITS]))
		else $error("done high while the pc line is still being read");

endmodule

bind fetch_top fetch_assertions u_assert (
	.clk          (clk),
	.rst_n        (rst_n),
	.done         (done),
	.current_pc   (current_pc),
	.addr_out_host(addr_out_host),
	.op_host      (op_host)
);

// File: tests/fetch_clock.sv
// testbench clock and reset generator
// free-running clock, reset held low for a fixed number of cycles

`timescale 1ns/100ps

module fetch_clock #(
	parameter int PERIOD       = 20,
	parameter int RESET_CYCLES = 8
) (
	output logic clk,
	output logic rst_n
);

	// clock starts low, first rising edge at half a period
	initial begin
		clk = 1'b0;
		forever #(PERIOD/2) clk = ~clk;
	end

	// release lands on a falling edge, away from the sampling edge
	initial begin
		rst_n = 1'b0;
		#(PERIOD*RESET_CYCLES);
		rst_n = 1'b1;
	end

endmodule

// File: hw/fetch_top.sv
// fetch stage top level
// program counter, line buffer and instruction selector
// plain host memory controller ports, read only

`timescale 1ns/100ps

module fetch_top
	import fetch_pkg::*;
	import host_mem_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  addr_t    in_pc_next,
	input  logic     stall,
	input  logic     flush,
	input  logic     restore,
	input  addr_t    pc_before_int,
	input  logic     use_cpu_injection,
	input  instr_t   cpu_injection,
	input  logic     use_int_instr,
	input  instr_t   int_instr,
	input  line_t    data_in_host,
	input  logic     rd_valid_host,
	output instr_t   instr,
	output addr_t    current_pc,
	output logic     done,
	output addr_t    addr_out_host,
	output host_op_t op_host
);

	addr_t pc;
	line_t line;

	// pc register
	fetch_pc u_pc (
		.clk          (clk),
		.rst_n        (rst_n),
		.in_pc_next   (in_pc_next),
		.stall        (stall),
		.flush        (flush),
		.restore      (restore),
		.pc_before_int(pc_before_int),
		.pc           (pc)
	);

	// line buffer, talks to the host controller
	instr_line_buffer u_buf (
		.clk          (clk),
		.rst_n        (rst_n),
		.pc           (pc),
		.data_in_host (data_in_host),
		.rd_valid_host(rd_valid_host),
		.addr_out_host(addr_out_host),
		.op_host      (op_host),
		.line         (line),
		.done         (done)
	);

	// issued instruction
	instr_select u_sel (
		.pc               (pc),
		.line             (line),
		.flush            (flush),
		.use_cpu_injection(use_cpu_injection),
		.use_int_instr    (use_int_instr),
		.cpu_injection    (cpu_injection),
		.int_instr        (int_instr),
		.instr            (instr)
	);

	// interrupt logic saves this pc
	assign current_pc = pc;

endmodule

// File: hw/instr_select.sv
// word extraction from the buffered line
// issue priority: flush NOP, cpu injection, interrupt injection, memory

`timescale 1ns/100ps

module instr_select
	import fetch_pkg::*;
	import host_mem_pkg::*;
(
	input  addr_t  pc,
	input  line_t  line,
	input  logic   flush,
	input  logic   use_cpu_injection,
	input  logic   use_int_instr,
	input  instr_t cpu_injection,
	input  instr_t int_instr,
	output instr_t instr
);

	instr_t    words [LINE_WORDS];
	word_idx_t word_idx;
	instr_t    mem_word;

	// split the line, word 0 in the low bits
	always_comb begin
		for (int i = 0; i < LINE_WORDS; i++) begin
			words[i] = line[i*32 +: 32];
		end
	end

	// word select from pc bits 5:2
	assign word_idx = pc[LINE_OFFSET_BITS-1:2];
	assign mem_word = words[word_idx];

	// injections only reach decode when no flush is pending
	always_comb begin
		if (flush) begin
			instr = NOP_INSTR;
		end else if (use_cpu_injection) begin
			instr = cpu_injection;
		end else if (use_int_instr) begin
			instr = int_instr;
		end else begin
			instr = mem_word;
		end
	end

endmodule

// File: hw/instr_line_buffer.sv
// one-line instruction buffer
// tag compare against pc forms the done level
// refill FSM issues host line reads on a miss

`timescale 1ns/100ps

module instr_line_buffer
	import fetch_pkg::*;
	import host_mem_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  addr_t    pc,
	input  line_t    data_in_host,
	input  logic     rd_valid_host,
	output addr_t    addr_out_host,
	output host_op_t op_host,
	output line_t    line,
	output logic     done
);

	refill_state_t state_q;
	refill_state_t state_d;

	// stored line, its tag and valid bit
	line_t      line_q;
	line_addr_t tag_q;
	logic       valid_q;

	// line index of the read in flight
	line_addr_t refill_tag_q;

	line_addr_t pc_tag;
	logic       hit;
	logic       capture;
	logic       start_refill;

	// line index of the current pc
	assign pc_tag = pc[31:LINE_OFFSET_BITS];

	// hit is purely combinational, zero latency on the fetch path
	assign hit = valid_q && (tag_q == pc_tag);

	// only look for a miss while no refill is running
	assign start_refill = (state_q == IDLE) && !hit;

	// host may answer as early as the request cycle
	assign capture = (state_q != IDLE) && rd_valid_host;

	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE: begin
				if (!hit) begin
					state_d = REQUEST;
				end
			end
			REQUEST: begin
				// read goes out this cycle
				if (rd_valid_host) begin
					state_d = IDLE;
				end else begin
					state_d = WAIT_DATA;
				end
			end
			WAIT_DATA: begin
				// wait for the single-cycle data pulse
				if (rd_valid_host) begin
					state_d = IDLE;
				end
			end
			default: begin
				state_d = IDLE;
			end
		endcase
	end

	// control state, cleared by reset
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= IDLE;
			valid_q <= 1'b0;
		end else begin
			state_q <= state_d;
			if (capture) begin
				valid_q <= 1'b1;
			end
		end
	end

	// payload registers
	always_ff @(posedge clk) begin
		// latch the requested index when the miss is seen
		if (start_refill) begin
			refill_tag_q <= pc_tag;
		end
		// returned line keeps the index it was requested for
		// even if pc has moved on meanwhile
		if (capture) begin
			line_q <= data_in_host;
			tag_q  <= refill_tag_q;
		end
	end

	// read stays asserted until the cycle after the data pulse
	always_comb begin
		case (state_q)
			REQUEST, WAIT_DATA: op_host = HOST_READ;
			default:            op_host = HOST_IDLE;
		endcase
	end

	// line base address while a read is outstanding, quiet otherwise
	assign addr_out_host = (state_q != IDLE) ?
		{refill_tag_q, {LINE_OFFSET_BITS{1'b0}}} : '0;

	assign line = line_q;
	assign done = hit;

endmodule

// File: hw/fetch_pc.sv
// program counter register of the fetch stage
// next-value selection for restore, stall and flush

`timescale 1ns/100ps

module fetch_pc
	import fetch_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n,
	input  addr_t in_pc_next,
	input  logic  stall,
	input  logic  flush,
	input  logic  restore,
	input  addr_t pc_before_int,
	output addr_t pc
);

	addr_t pc_q;
	addr_t pc_d;

	// next pc priority
	// restore from interrupt wins over everything
	// a stall holds pc unless a flush redirects fetch
	// a taken branch flushes, so it must move pc even under stall
	always_comb begin
		if (restore) begin
			pc_d = pc_before_int;
		end else if (stall && !flush) begin
			pc_d = pc_q;
		end else begin
			pc_d = in_pc_next;
		end
	end

	// pc register, starts at the instruction memory base
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc_q <= RESET_PC;
		end else begin
			pc_q <= pc_d;
		end
	end

	assign pc = pc_q;

endmodule

// File: hw/host_mem_pkg.sv
// host memory controller definitions
// line geometry, line and index types
// host operation encoding and refill FSM states

package host_mem_pkg;

	// instruction words per cache line
	localparam int LINE_WORDS = 16;

	// byte offset inside a 64-byte line
	localparam int LINE_OFFSET_BITS = 6;

	// one full line as moved by the host controller
	typedef logic [LINE_WORDS*32-1:0] line_t;

	// line index, the address bits above the offset
	typedef logic [32-LINE_OFFSET_BITS-1:0] line_addr_t;

	// word position inside a line
	typedef logic [$clog2(LINE_WORDS)-1:0] word_idx_t;

	// controller op encoding, write exists but fetch never uses it
	typedef enum logic [1:0] {
		HOST_IDLE  = 2'b00,
		HOST_READ  = 2'b01,
		HOST_WRITE = 2'b10
	} host_op_t;

	// line buffer refill FSM
	typedef enum logic [1:0] {IDLE, REQUEST, WAIT_DATA} refill_state_t;

endpackage

// File: hw/fetch_pkg.sv
// processor-side fetch definitions
// address and instruction word types
// reset program counter and the flush NOP encoding

package fetch_pkg;

	// width of a byte address on the processor side
	localparam int ADDR_BITS = 32;

	// every instruction is one 32-bit word
	localparam int INSTR_BITS = 32;

	// byte address of an instruction
	typedef logic [ADDR_BITS-1:0] addr_t;

	// raw instruction word as issued to decode
	typedef logic [INSTR_BITS-1:0] instr_t;

	// opcode field sits in the top five bits
	localparam int OPCODE_BITS = 5;

	// opcode value of the no-operation instruction
	localparam logic [OPCODE_BITS-1:0] NOP_OPCODE = 5'b01111;

	// first instruction after reset
	// instruction memory starts here
	localparam addr_t RESET_PC = 32'h0600_2000;

	// bubble issued while a flush is active
	// only the opcode is set, operand fields stay zero
	localparam instr_t NOP_INSTR = {NOP_OPCODE, {(INSTR_BITS-OPCODE_BITS){1'b0}}};

endpackage
